// File: dv/multiCycleCpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module multiCycleCpuTb import cpuPkg::*; ();

	// Program lengths in cycles, 5 per instruction and 4 per store
	localparam int programCycles = 87 + 190 + 64 + 23 + 22;
	localparam int timeoutCycles = programCycles * 3 / 2;
	localparam logic [31:0] resultBase = 32'h600;
	localparam int resultWord = 384;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [31:0] memAddr;
	logic [31:0] memWriteData;
	logic memWrite;
	logic [31:0] memReadData;

	logic [31:0] mem [1024];
	logic [31:0] progQ [$];
	logic [31:0] storeAddrQ [$];
	logic [31:0] lcgState = 32'h0723_93f8;
	int cycleCount = 0;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int failedTests = 0;

	string rNames [8] = '{"ADD", "SUB", "AND", "OR", "XOR", "SLT", "SLL", "SRL"};
	logic [2:0] rFunct3 [8] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010, 3'b001, 3'b101};
	string iNames [5] = '{"ADDI", "ANDI", "ORI", "XORI", "SLTI"};
	logic [2:0] iFunct3 [5] = '{3'b000, 3'b111, 3'b110, 3'b100, 3'b010};
	// I-type op mapped onto the matching R-type computation
	int iToR [5] = '{0, 2, 3, 4, 5};

	multiCycleCpu #(.addrWidth(5), .resetPc(32'h0)) dut_i (
		.clk(clk),
		.reset(reset),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memWrite(memWrite),
		.memReadData(memReadData)
	);

	always #50 clk = ~clk;

	// Word memory, read combinationally
	assign memReadData = mem[memAddr[11:2]];

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > timeoutCycles) begin
			$display("Timeout: the run did not end within %0d clock cycles", timeoutCycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opAluReg};
	endfunction

	function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input opcodeT op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] sTypeWord(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
	endfunction

	// Reference results in R-type order
	function automatic logic [31:0] expectAlu(input int k, input logic [31:0] a,
		input logic [31:0] b);
		case (k)
			0: return a + b;
			1: return a - b;
			2: return a & b;
			3: return a | b;
			4: return a ^ b;
			5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			6: return a << b[4:0];
			default: return a >> b[4:0];
		endcase
	endfunction

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			$display("FAIL %s: expected %h, actual %h", what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic finishTest(input string testName, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("ok    %s", testName);
		end else begin
			failedTests++;
			$display("test %s failed with %0d errors", testName, errorCount - errorsBefore);
		end
	endtask

	// Fill pattern mixes every address bit
	task automatic prepareMemory();
		for (int i = 0; i < 1024; i++) begin
			mem[i] = {i[15:0], ~i[15:0]} ^ 32'h5A3C_96E1;
		end
		progQ.delete();
		storeAddrQ.delete();
	endtask

	task automatic pushInstr(input logic [31:0] word);
		progQ.push_back(word);
	endtask

	task automatic queueStore(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] offset, input logic [31:0] address);
		progQ.push_back(sTypeWord(offset, rs2, rs1));
		storeAddrQ.push_back(address);
	endtask

	task automatic resetCpu(input string testName);
		@(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		repeat (2) begin
			@(negedge clk);
			if (memWrite !== 1'b0) begin
				$display("Error in %s: memory write strobe was not low during reset", testName);
				errorCount++;
			end
			@(posedge clk);
		end
		reset <= 1'b0;
	endtask

	////////////////////////////////////////
	// Program runner
	////////////////////////////////////////

	// Steps each instruction through its cycles and watches the store strobe
	task automatic runProgram(input string testName);
		int cycles;
		int writesSeen;
		logic expectWrite;
		logic sampledWrite;
		logic [31:0] sampledAddr;
		logic [31:0] sampledData;
		writesSeen = 0;
		foreach (progQ[i]) begin
			mem[i] = progQ[i];
		end
		resetCpu(testName);
		foreach (progQ[i]) begin
			cycles = (progQ[i][6:0] == opStore) ? 4 : 5;
			for (int c = 0; c < cycles; c++) begin
				@(negedge clk);
				expectWrite = (cycles == 4) && (c == 3);
				sampledWrite = memWrite;
				sampledAddr = memAddr;
				sampledData = memWriteData;
				if (sampledWrite !== expectWrite) begin
					$display("Error in %s: memory write strobe was %b in cycle %0d of %s %0d",
						testName, sampledWrite, c, "instruction", i);
					errorCount++;
				end
				if (sampledWrite === 1'b1) begin
					if (writesSeen < storeAddrQ.size()) begin
						checkValue($sformatf("%s store address %0d", testName, writesSeen),
							storeAddrQ[writesSeen], sampledAddr);
					end
					writesSeen++;
				end
				@(posedge clk);
				if (sampledWrite === 1'b1) begin
					mem[sampledAddr[11:2]] = sampledData;
				end
			end
		end
		@(negedge clk);
		checkValue($sformatf("%s store count", testName), storeAddrQ.size(), writesSeen);
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic testRType();
		logic [31:0] a;
		logic [31:0] b;
		int errorsBefore;
		errorsBefore = errorCount;
		a = nextRandom();
		b = nextRandom();
		prepareMemory();
		mem[256] = a;
		mem[257] = b;
		pushInstr(iTypeWord(12'h600, 5'd0, 3'b000, 5'd5, opAluImm));
		pushInstr(iTypeWord(12'h400, 5'd0, 3'b010, 5'd1, opLoad));
		pushInstr(iTypeWord(12'h404, 5'd0, 3'b010, 5'd2, opLoad));
		for (int k = 0; k < 8; k++) begin
			pushInstr(rTypeWord((k == 1) ? 7'h20 : 7'h00, 5'd2, 5'd1, rFunct3[k], 5'd3));
			queueStore(5'd3, 5'd5, 12'(4 * k), resultBase + 32'(4 * k));
		end
		runProgram("rTypeArith");
		for (int k = 0; k < 8; k++) begin
			checkValue($sformatf("rTypeArith %s", rNames[k]), expectAlu(k, a, b),
				mem[resultWord + k]);
		end
		finishTest("rTypeArith", errorsBefore);
	endtask

	task automatic testImmediates();
		logic [31:0] c;
		logic [31:0] srcVal;
		logic [11:0] imm;
		int slot;
		int errorsBefore;
		errorsBefore = errorCount;
		c = nextRandom();
		prepareMemory();
		mem[260] = c;
		pushInstr(iTypeWord(12'h600, 5'd0, 3'b000, 5'd5, opAluImm));
		pushInstr(iTypeWord(12'h410, 5'd0, 3'b010, 5'd1, opLoad));
		slot = 0;
		for (int s = 0; s < 2; s++) begin
			for (int m = 0; m < 4; m++) begin
				imm = (m < 2) ? 12'hFFB : 12'h2A3;
				if (m % 2 == 1) begin
					continue;
				end
				for (int k = 0; k < 5; k++) begin
					pushInstr(iTypeWord(imm, 5'(s), iFunct3[k], 5'd3, opAluImm));
					queueStore(5'd3, 5'd5, 12'(4 * slot), resultBase + 32'(4 * slot));
					slot++;
				end
			end
		end
		runProgram("immediates");
		slot = 0;
		for (int s = 0; s < 2; s++) begin
			srcVal = (s == 0) ? 32'd0 : c;
			for (int m = 0; m < 4; m += 2) begin
				imm = (m < 2) ? 12'hFFB : 12'h2A3;
				for (int k = 0; k < 5; k++) begin
					checkValue($sformatf("immediates %s x%0d imm %h", iNames[k], s, imm),
						expectAlu(iToR[k], srcVal, {{20{imm[11]}}, imm}),
						mem[resultWord + slot]);
					slot++;
				end
			end
		end
		finishTest("immediates", errorsBefore);
	endtask

	task automatic testLoadLanes();
		logic [31:0] w;
		int errorsBefore;
		errorsBefore = errorCount;
		// Top bit of every byte set so sign extension shows
		w = nextRandom() | 32'h8080_8080;
		prepareMemory();
		mem[264] = w;
		pushInstr(iTypeWord(12'h600, 5'd0, 3'b000, 5'd5, opAluImm));
		pushInstr(iTypeWord(12'h420, 5'd0, 3'b000, 5'd6, opAluImm));
		for (int j = 0; j < 4; j++) begin
			pushInstr(iTypeWord(12'(j), 5'd6, 3'b000, 5'd3, opLoad));
			queueStore(5'd3, 5'd5, 12'(4 * j), resultBase + 32'(4 * j));
		end
		for (int j = 0; j < 2; j++) begin
			pushInstr(iTypeWord(12'(2 * j), 5'd6, 3'b001, 5'd3, opLoad));
			queueStore(5'd3, 5'd5, 12'(16 + 4 * j), resultBase + 32'(16 + 4 * j));
		end
		runProgram("loadLanes");
		for (int j = 0; j < 4; j++) begin
			checkValue($sformatf("loadLanes LB offset %0d", j),
				{{24{w[8 * j + 7]}}, w[8 * j +: 8]}, mem[resultWord + j]);
		end
		for (int j = 0; j < 2; j++) begin
			checkValue($sformatf("loadLanes LH offset %0d", 2 * j),
				{{16{w[16 * j + 15]}}, w[16 * j +: 16]}, mem[resultWord + 4 + j]);
		end
		finishTest("loadLanes", errorsBefore);
	endtask

	task automatic testRegZero();
		int errorsBefore;
		errorsBefore = errorCount;
		prepareMemory();
		mem[256] = nextRandom() | 32'd1;
		mem[resultWord] = 32'hFFFF_FFFF;
		mem[resultWord + 1] = 32'hFFFF_FFFF;
		pushInstr(iTypeWord(12'h600, 5'd0, 3'b000, 5'd5, opAluImm));
		pushInstr(iTypeWord(12'h123, 5'd0, 3'b000, 5'd0, opAluImm));
		queueStore(5'd0, 5'd5, 12'd0, resultBase);
		pushInstr(iTypeWord(12'h400, 5'd0, 3'b010, 5'd0, opLoad));
		queueStore(5'd0, 5'd5, 12'd4, resultBase + 32'd4);
		runProgram("regZero");
		checkValue("regZero after ADDI", 32'd0, mem[resultWord]);
		checkValue("regZero after LW", 32'd0, mem[resultWord + 1]);
		finishTest("regZero", errorsBefore);
	endtask

	// Back to back stores, one with a negative offset
	task automatic testStoreTiming();
		logic [31:0] r;
		logic [11:0] value;
		int errorsBefore;
		errorsBefore = errorCount;
		r = nextRandom();
		value = {1'b0, r[10:0]};
		prepareMemory();
		pushInstr(iTypeWord(12'h600, 5'd0, 3'b000, 5'd5, opAluImm));
		pushInstr(iTypeWord(value, 5'd0, 3'b000, 5'd7, opAluImm));
		queueStore(5'd7, 5'd5, 12'd0, resultBase);
		queueStore(5'd7, 5'd5, 12'hFF8, resultBase - 32'd8);
		queueStore(5'd7, 5'd5, 12'h010, resultBase + 32'h10);
		runProgram("storeTiming");
		checkValue("storeTiming offset 0", {20'd0, value}, mem[resultWord]);
		checkValue("storeTiming offset -8", {20'd0, value}, mem[resultWord - 2]);
		checkValue("storeTiming offset 16", {20'd0, value}, mem[resultWord + 4]);
		finishTest("storeTiming", errorsBefore);
	endtask

	initial begin
		testRType();
		testImmediates();
		testLoadLanes();
		testRegZero();
		testStoreTiming();
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: multiCycleCpu.f
src/cpuPkg.sv
src/alu.sv
src/registerFile.sv
src/immediateGenerator.sv
src/mainController.sv
src/dataPath.sv
src/multiCycleCpu.sv
dv/multiCycleCpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the multicycle CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary -Wno-fatal -f multiCycleCpu.f --top-module multiCycleCpuTb \
	-o multiCycleCpuSim \
	&& ./obj_dir/multiCycleCpuSim | tee sim.log \
	|| { echo "Build or simulation run failed"; exit 1; }

grep -qx "PASS: all tests" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpuPkg::*; (
	input wire [dataWidth-1:0] a,
	input wire [dataWidth-1:0] b,
	input wire opcodeT opCode,
	input wire funct3T funct3,
	input wire funct7Bit5,
	input wire aluOverride,
	output logic [dataWidth-1:0] result
);

	logic subtract;
	logic addressOp;

	// funct7 only qualifies register ops
	assign subtract = funct7Bit5 && (opCode != opAluImm);

	// Loads and stores only need base plus offset
	assign addressOp = (opCode == opLoad) || (opCode == opStore);

	always_comb begin
		result = a + b;
		if (!aluOverride && !addressOp) begin
			case (funct3)
				f3Add: begin
					if (subtract) begin
						result = a - b;
					end else begin
						result = a + b;
					end
				end
				f3Sll: result = a << b[4:0];
				f3Slt: result = {{(dataWidth-1){1'b0}}, ($signed(a) < $signed(b))};
				f3Xor: result = a ^ b;
				f3Srl: result = a >> b[4:0];
				f3Or: result = a | b;
				f3And: result = a & b;
				default: result = a + b;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int dataWidth = 32;

	// ADDI x0, x0, 0
	localparam logic [dataWidth-1:0] nopInstruction = 32'h0000_0013;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		opAluReg = 7'b0110011,
		opAluImm = 7'b0010011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011
	} opcodeT;

	// ALU ops, LB and LH share the add and shift-left codes
	typedef enum logic [2:0] {
		f3Add = 3'b000,
		f3Sll = 3'b001,
		f3Slt = 3'b010,
		f3Xor = 3'b100,
		f3Srl = 3'b101,
		f3Or  = 3'b110,
		f3And = 3'b111
	} funct3T;

	// LW and SW use the SLT code
	localparam funct3T f3Word = f3Slt;

	typedef enum logic [3:0] {
		stFetch,
		stDecode,
		stExecuteR,
		stExecuteI,
		stMemory,
		stMemoryStore,
		stWriteback,
		stWritebackMem
	} controlStateT;

	typedef enum logic {srcAPc, srcARegOut} aluSrcAT;

	typedef enum logic [1:0] {srcBConst4, srcBRegOut, srcBImmed} aluSrcBT;

	typedef enum logic [1:0] {wbExecute, wbMemWord, wbMemHalf, wbMemByte} regWriteSrcT;

endpackage

`default_nettype wire

// File: src/dataPath.sv
`timescale 1ns/1ps
`default_nettype none

module dataPath import cpuPkg::*; #(
	parameter int addrWidth = 5,
	parameter logic [dataWidth-1:0] resetPc = '0
) (
	input wire clk,
	input wire reset,
	input wire pcWrite,
	input wire irWrite,
	input wire regFileWrite,
	input wire aluOverride,
	input wire memAddrSelData,
	input wire aluSrcAT aluSrcA,
	input wire aluSrcBT aluSrcB,
	input wire regWriteSrcT regFileWriteSrc,
	output opcodeT opCode,
	output funct3T funct3,
	output logic [dataWidth-1:0] memAddr,
	output logic [dataWidth-1:0] memWriteData,
	input wire [dataWidth-1:0] memReadData
);

	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] instr;
	logic [dataWidth-1:0] regA;
	logic [dataWidth-1:0] regB;
	logic [dataWidth-1:0] aluOut;
	logic [dataWidth-1:0] memData;
	logic [dataWidth-1:0] readDataA;
	logic [dataWidth-1:0] readDataB;
	logic [dataWidth-1:0] immediate;
	logic [dataWidth-1:0] aluInA;
	logic [dataWidth-1:0] aluInB;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] writeData;
	logic [7:0] byteLane;
	logic [15:0] halfLane;

	assign opCode = opcodeT'(instr[6:0]);
	assign funct3 = funct3T'(instr[14:12]);

	assign memAddr = memAddrSelData ? aluOut : pc;
	assign memWriteData = regB;

	////////////////////////////////////////
	// Architectural registers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetPc;
			instr <= nopInstruction;
		end else begin
			if (pcWrite) begin
				pc <= aluOut;
			end
			if (irWrite) begin
				instr <= memReadData;
			end
		end
	end

	// Operand and result registers follow their sources every cycle
	always_ff @(posedge clk) begin
		regA <= readDataA;
		regB <= readDataB;
		aluOut <= aluResult;
		if (memAddrSelData) begin
			memData <= memReadData;
		end
	end

	////////////////////////////////////////
	// ALU operands and writeback
	////////////////////////////////////////

	assign aluInA = (aluSrcA == srcAPc) ? pc : regA;

	always_comb begin
		case (aluSrcB)
			srcBConst4: aluInB = dataWidth'(4);
			srcBImmed: aluInB = immediate;
			default: aluInB = regB;
		endcase
	end

	// Lane picked by the low address bits still held in aluOut
	always_comb begin
		case (aluOut[1:0])
			2'd0: byteLane = memData[7:0];
			2'd1: byteLane = memData[15:8];
			2'd2: byteLane = memData[23:16];
			default: byteLane = memData[31:24];
		endcase
		halfLane = aluOut[1] ? memData[31:16] : memData[15:0];
	end

	always_comb begin
		case (regFileWriteSrc)
			wbMemWord: writeData = memData;
			wbMemHalf: writeData = {{(dataWidth-16){halfLane[15]}}, halfLane};
			wbMemByte: writeData = {{(dataWidth-8){byteLane[7]}}, byteLane};
			default: writeData = aluOut;
		endcase
	end

	alu alu_i (
		.a(aluInA),
		.b(aluInB),
		.opCode(opCode),
		.funct3(funct3),
		.funct7Bit5(instr[30]),
		.aluOverride(aluOverride),
		.result(aluResult)
	);

	registerFile #(.addrWidth(addrWidth)) registerFile_i (
		.clk(clk),
		.reset(reset),
		.readAddrA(instr[15 +: addrWidth]),
		.readAddrB(instr[20 +: addrWidth]),
		.writeAddr(instr[7 +: addrWidth]),
		.writeData(writeData),
		.writeEnable(regFileWrite),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	immediateGenerator immediateGenerator_i (
		.instruction(instr),
		.immediate(immediate)
	);

endmodule

`default_nettype wire

// File: src/immediateGenerator.sv
`timescale 1ns/1ps
`default_nettype none

module immediateGenerator import cpuPkg::*; (
	input wire [dataWidth-1:0] instruction,
	output logic [dataWidth-1:0] immediate
);

	logic [11:0] field;
	logic isStore;

	assign isStore = (instruction[6:0] == opStore);

	// S-type splits the offset around rd
	always_comb begin
		if (isStore) begin
			field = {instruction[31:25], instruction[11:7]};
		end else begin
			field = instruction[31:20];
		end
	end

	// Sign comes from bit 31 in both layouts
	assign immediate = {{(dataWidth-12){instruction[31]}}, field};

endmodule

`default_nettype wire

// File: src/mainController.sv
`timescale 1ns/1ps
`default_nettype none

module mainController import cpuPkg::*; (
	input wire clk,
	input wire reset,
	input wire opcodeT opCode,
	input wire funct3T funct3,
	output logic pcWrite,
	output logic irWrite,
	output logic regFileWrite,
	output logic memWrite,
	output logic aluOverride,
	output logic memAddrSelData,
	output aluSrcAT aluSrcA,
	output aluSrcBT aluSrcB,
	output regWriteSrcT regFileWriteSrc
);

	controlStateT state;
	controlStateT nextState;
	aluSrcBT operandSrcB;

	// Operand B as chosen by the execute state for this opcode.
	// Later states keep it so aluOut reloads the same value
	assign operandSrcB = (opCode == opAluImm || opCode == opLoad || opCode == opStore)
		? srcBImmed : srcBRegOut;

	////////////////////////////////////////
	// State register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stFetch;
		end else begin
			state <= nextState;
		end
	end

	////////////////////////////////////////
	// Next state and strobes
	////////////////////////////////////////

	always_comb begin
		pcWrite = 1'b0;
		irWrite = 1'b0;
		regFileWrite = 1'b0;
		memWrite = 1'b0;
		aluOverride = 1'b0;
		memAddrSelData = 1'b0;
		aluSrcA = srcARegOut;
		aluSrcB = operandSrcB;
		regFileWriteSrc = wbExecute;
		nextState = stFetch;

		case (state)
			stFetch: begin
				// IR takes the word at PC, ALU forms PC + 4
				irWrite = 1'b1;
				aluOverride = 1'b1;
				aluSrcA = srcAPc;
				aluSrcB = srcBConst4;
				nextState = stDecode;
			end
			stDecode: begin
				pcWrite = 1'b1;
				case (opCode)
					opAluImm, opLoad, opStore: nextState = stExecuteI;
					default: nextState = stExecuteR;
				endcase
			end
			stExecuteR: begin
				aluSrcB = srcBRegOut;
				nextState = stMemory;
			end
			stExecuteI: begin
				aluSrcB = srcBImmed;
				if (opCode == opStore) begin
					nextState = stMemoryStore;
				end else begin
					nextState = stMemory;
				end
			end
			stMemory: begin
				memAddrSelData = 1'b1;
				if (opCode == opLoad) begin
					nextState = stWritebackMem;
				end else begin
					nextState = stWriteback;
				end
			end
			stMemoryStore: begin
				// Store is done here, no register write follows
				memAddrSelData = 1'b1;
				memWrite = 1'b1;
				nextState = stFetch;
			end
			stWriteback: begin
				regFileWrite = 1'b1;
				nextState = stFetch;
			end
			stWritebackMem: begin
				regFileWrite = 1'b1;
				case (funct3)
					f3Add: regFileWriteSrc = wbMemByte;
					f3Sll: regFileWriteSrc = wbMemHalf;
					f3Word: regFileWriteSrc = wbMemWord;
					default: regFileWriteSrc = wbMemWord;
				endcase
				nextState = stFetch;
			end
			default: begin
				nextState = stFetch;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/multiCycleCpu.sv
`timescale 1ns/1ps
`default_nettype none

module multiCycleCpu import cpuPkg::*; #(
	parameter int addrWidth = 5,
	parameter logic [dataWidth-1:0] resetPc = '0
) (
	input wire clk,
	input wire reset,
	output logic [dataWidth-1:0] memAddr,
	output logic [dataWidth-1:0] memWriteData,
	output logic memWrite,
	input wire [dataWidth-1:0] memReadData
);

	logic pcWrite;
	logic irWrite;
	logic regFileWrite;
	logic aluOverride;
	logic memAddrSelData;
	aluSrcAT aluSrcA;
	aluSrcBT aluSrcB;
	regWriteSrcT regFileWriteSrc;
	opcodeT opCode;
	funct3T funct3;

	// Controller drives the memory write strobe straight out
	mainController mainController_i (
		.clk(clk),
		.reset(reset),
		.opCode(opCode),
		.funct3(funct3),
		.pcWrite(pcWrite),
		.irWrite(irWrite),
		.regFileWrite(regFileWrite),
		.memWrite(memWrite),
		.aluOverride(aluOverride),
		.memAddrSelData(memAddrSelData),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.regFileWriteSrc(regFileWriteSrc)
	);

	dataPath #(.addrWidth(addrWidth), .resetPc(resetPc)) dataPath_i (
		.clk(clk),
		.reset(reset),
		.pcWrite(pcWrite),
		.irWrite(irWrite),
		.regFileWrite(regFileWrite),
		.aluOverride(aluOverride),
		.memAddrSelData(memAddrSelData),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.regFileWriteSrc(regFileWriteSrc),
		.opCode(opCode),
		.funct3(funct3),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memReadData(memReadData)
	);

endmodule

`default_nettype wire

// File: src/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile import cpuPkg::*; #(
	parameter int addrWidth = 5
) (
	input wire clk,
	input wire reset,
	input wire [addrWidth-1:0] readAddrA,
	input wire [addrWidth-1:0] readAddrB,
	input wire [addrWidth-1:0] writeAddr,
	input wire [dataWidth-1:0] writeData,
	input wire writeEnable,
	output logic [dataWidth-1:0] readDataA,
	output logic [dataWidth-1:0] readDataB
);

	localparam int depth = 2 ** addrWidth;

	logic [dataWidth-1:0] regs [depth];

	// Entry 0 is cleared by reset and never written
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < depth; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire
